/* wb_obi_pkg.sv */
`default_nettype none

package wb_obi_pkg;

    localparam int ADDR_W = 32;          // Byte address width on both OBI and Wishbone
    localparam int DATA_W = 32;          // Data bus width
    localparam int BE_W   = DATA_W / 8;  // One byte enable per data byte

    // Request payload an OBI master presents together with req
    typedef struct packed {
        logic [ADDR_W-1:0] addr;   // Byte address as issued by the master
        logic              we;     // High for a write, low for a read
        logic [BE_W-1:0]   be;     // Byte lanes touched by a write
        logic [DATA_W-1:0] wdata;  // Write data, ignored on reads
    } obi_req_t;

    // Everything a Wishbone master drives toward the slave
    typedef struct packed {
        logic              cyc;  // Cycle in progress
        logic              stb;  // Strobe, rises and falls with cyc in classic cycles
        logic              we;   // Write enable
        logic [BE_W-1:0]   sel;  // Byte lane select
        logic [ADDR_W-1:0] adr;  // Byte address
        logic [DATA_W-1:0] dat;  // Write data
    } wb_req_t;

    // Everything a Wishbone slave drives back
    typedef struct packed {
        logic              ack;  // Transfer done for the current cycle
        logic [DATA_W-1:0] dat;  // Read data, valid with ack
    } wb_rsp_t;

    // Bridge phases for one OBI transaction
    typedef enum logic [1:0] {
        BR_IDLE,   // Waiting for a request, gnt follows req here
        BR_AWAIT,  // Wishbone cycle open, waiting for ack
        BR_VALID   // Response presented to the OBI master for one cycle
    } bridge_state_e;

    // Bus ownership seen by the arbiter
    typedef enum logic [1:0] {
        ARB_IDLE,  // Nobody owns the slave
        ARB_OWN0,  // Master 0 owns the slave
        ARB_OWN1   // Master 1 owns the slave
    } arb_state_e;

endpackage

`default_nettype wire

/* obi_wb_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

module obi_wb_bridge #(
    parameter int MEM_AW = 10  // Low address bits kept inside the memory window
) (
    input  wire                                wb_clk_i,        // Bus clock
    input  wire                                soc_rst_ni,      // Asynchronous reset, active low
    input  wire                                obi_req_i,       // Master has a request pending
    input  wire wb_obi_pkg::obi_req_t          obi_req_data_i,  // Request payload, stable while req is high
    output logic                               obi_gnt_o,       // Request accepted at this edge
    output logic                               obi_rvalid_o,    // One pulse per granted request
    output logic [wb_obi_pkg::DATA_W-1:0]      obi_rdata_o,     // Read data, valid with rvalid on reads
    output wb_obi_pkg::wb_req_t                wb_req_o,        // Wishbone master outputs
    input  wire wb_obi_pkg::wb_rsp_t           wb_rsp_i         // Wishbone slave response
);

    wb_obi_pkg::bridge_state_e     state_q;   // Current phase of the transaction
    wb_obi_pkg::bridge_state_e     state_d;   // Phase for the next cycle
    wb_obi_pkg::obi_req_t          req_q;     // Captured request with the windowed address
    logic [wb_obi_pkg::DATA_W-1:0] rdata_q;   // Read data held for the master
    logic [wb_obi_pkg::ADDR_W-1:0] win_addr;  // Incoming address cut down to the window
    logic                          ack_seen;  // Slave finished our open cycle

    // Only the low MEM_AW bits survive, upper bits are forced to zero
    assign win_addr = {{(wb_obi_pkg::ADDR_W - MEM_AW){1'b0}}, obi_req_data_i.addr[MEM_AW-1:0]};
    assign ack_seen = wb_rsp_i.ack & (state_q == wb_obi_pkg::BR_AWAIT);

    // A busy bridge withholds gnt so the master keeps req up
    assign obi_gnt_o    = obi_req_i & (state_q == wb_obi_pkg::BR_IDLE);
    assign obi_rvalid_o = (state_q == wb_obi_pkg::BR_VALID);
    assign obi_rdata_o  = rdata_q;

    always_comb begin
        state_d = state_q;  // Hold unless an event moves us on
        unique case (state_q)
            wb_obi_pkg::BR_IDLE: begin
                if (obi_req_i) begin
                    state_d = wb_obi_pkg::BR_AWAIT;  // Granted this cycle, open the bus cycle next
                end
            end
            wb_obi_pkg::BR_AWAIT: begin
                if (wb_rsp_i.ack) begin
                    state_d = wb_obi_pkg::BR_VALID;  // Cycle closes at this edge
                end
            end
            wb_obi_pkg::BR_VALID: begin
                state_d = wb_obi_pkg::BR_IDLE;  // Response shown for exactly one cycle
            end
            default: begin
                state_d = wb_obi_pkg::BR_IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i, negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            state_q <= wb_obi_pkg::BR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (obi_gnt_o) begin
            req_q      <= obi_req_data_i;  // Payload taken at the grant edge
            req_q.addr <= win_addr;        // Address replaced by its in-window alias
        end
        if (ack_seen && !req_q.we) begin
            rdata_q <= wb_rsp_i.dat;  // Writes leave the last read data in place
        end
    end

    // cyc and stb are held together for the whole classic cycle
    always_comb begin
        wb_req_o.cyc = (state_q == wb_obi_pkg::BR_AWAIT);
        wb_req_o.stb = (state_q == wb_obi_pkg::BR_AWAIT);
        wb_req_o.we  = req_q.we;
        wb_req_o.sel = req_q.be;
        wb_req_o.adr = req_q.addr;
        wb_req_o.dat = req_q.wdata;
    end

    // A grant is only given from idle and always opens a bus cycle on the next cycle
    a_gnt_opens_cycle: assert property (@(posedge wb_clk_i) disable iff (!soc_rst_ni)
        obi_gnt_o |-> (state_q == wb_obi_pkg::BR_IDLE) ##1 (wb_req_o.cyc && wb_req_o.stb))
        else $error("gnt outside idle or not followed by a Wishbone cycle");

    a_cyc_stb_equal: assert property (@(posedge wb_clk_i) disable iff (!soc_rst_ni)
        wb_req_o.cyc == wb_req_o.stb)
        else $error("cyc and stb differ");

endmodule

`default_nettype wire

/* wb_rr_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_rr_arbiter (
    input  wire                      wb_clk_i,    // Bus clock
    input  wire                      soc_rst_ni,  // Active low asynchronous reset
    input  wire wb_obi_pkg::wb_req_t m0_req_i,    // Request from master 0
    input  wire wb_obi_pkg::wb_req_t m1_req_i,    // Request from master 1
    output wb_obi_pkg::wb_rsp_t      m0_rsp_o,    // Response routed to master 0
    output wb_obi_pkg::wb_rsp_t      m1_rsp_o,    // Response routed to master 1
    output wb_obi_pkg::wb_req_t      s_req_o,     // Request forwarded to the slave
    input  wire wb_obi_pkg::wb_rsp_t s_rsp_i      // Response from the slave
);

    wb_obi_pkg::arb_state_e state_q;  // Current owner of the slave
    wb_obi_pkg::arb_state_e state_d;  // Owner for the next cycle
    logic                   last_q;   // High when master 1 was the most recent owner
    logic                   pick1;    // Master 1 wins the next idle slot

    // On a tie the master that did not own last time goes first
    assign pick1 = m1_req_i.cyc & (~m0_req_i.cyc | ~last_q);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            wb_obi_pkg::ARB_IDLE: begin
                if (m0_req_i.cyc || m1_req_i.cyc) begin
                    state_d = pick1 ? wb_obi_pkg::ARB_OWN1 : wb_obi_pkg::ARB_OWN0;
                end
            end
            wb_obi_pkg::ARB_OWN0, wb_obi_pkg::ARB_OWN1: begin
                if (s_rsp_i.ack) begin
                    state_d = wb_obi_pkg::ARB_IDLE;  // Bus is released at the ack edge
                end
            end
            default: begin
                state_d = wb_obi_pkg::ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge wb_clk_i, negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            state_q <= wb_obi_pkg::ARB_IDLE;
            last_q  <= 1'b1;  // Master 0 wins the first tie
        end else begin
            state_q <= state_d;
            if (state_q == wb_obi_pkg::ARB_IDLE && (m0_req_i.cyc || m1_req_i.cyc)) begin
                last_q <= pick1;  // Remember who took the bus
            end
        end
    end

    // Owner goes straight through while the loser sees ack low and zero data
    always_comb begin
        s_req_o  = '0;
        m0_rsp_o = '0;
        m1_rsp_o = '0;
        unique case (state_q)
            wb_obi_pkg::ARB_OWN0: begin
                s_req_o  = m0_req_i;
                m0_rsp_o = s_rsp_i;
            end
            wb_obi_pkg::ARB_OWN1: begin
                s_req_o  = m1_req_i;
                m1_rsp_o = s_rsp_i;
            end
            default: begin
                s_req_o = '0;  // Slave sees no strobe while idle
            end
        endcase
    end

    a_no_stb_idle: assert property (@(posedge wb_clk_i) disable iff (!soc_rst_ni)
        s_req_o.stb |-> (state_q != wb_obi_pkg::ARB_IDLE))
        else $error("stb forwarded with no owner");

endmodule

`default_nettype wire

/* wb_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_sram #(
    parameter int MEM_AW = 10  // Byte address bits decoded by the memory
) (
    input  wire                      wb_clk_i,    // Bus clock
    input  wire                      soc_rst_ni,  // Active low asynchronous reset
    input  wire wb_obi_pkg::wb_req_t wb_req_i,    // Wishbone request from the arbiter
    output wb_obi_pkg::wb_rsp_t      wb_rsp_o     // Registered ack and read data
);

    localparam int DEPTH = 2 ** (MEM_AW - 2);  // Words in the array

    logic [wb_obi_pkg::DATA_W-1:0] mem_q [DEPTH];  // Word array addressed by idx
    logic [wb_obi_pkg::DATA_W-1:0] rdat_q;         // Read word handed out with ack
    logic [MEM_AW-3:0]             idx;            // Word index from the byte address
    logic                          ack_q;          // One-cycle acknowledge
    logic                          hit;            // New access that has not been acked yet

    assign idx = wb_req_i.adr[MEM_AW-1:2];
    assign hit = wb_req_i.cyc & wb_req_i.stb & ~ack_q;  // No ack on two cycles in a row

    always_ff @(posedge wb_clk_i, negedge soc_rst_ni) begin
        if (!soc_rst_ni) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (hit && wb_req_i.we) begin
            for (int b = 0; b < wb_obi_pkg::BE_W; b++) begin
                if (wb_req_i.sel[b]) begin
                    mem_q[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];  // Only selected lanes change
                end
            end
        end
        if (hit && !wb_req_i.we) begin
            rdat_q <= mem_q[idx];  // Whole word is returned regardless of sel
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;

    a_ack_after_stb: assert property (@(posedge wb_clk_i) disable iff (!soc_rst_ni)
        wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else $error("ack without a strobe in the previous cycle");

endmodule

`default_nettype wire

/* obi_wb_subsys.sv */
`timescale 1ns/10ps
`default_nettype none

module obi_wb_subsys #(
    parameter int MEM_AW = 10  // Memory window in byte address bits
) (
    input  wire                           wb_clk_i,       // Bus clock
    input  wire                           soc_rst_ni,     // Asynchronous reset, active low
    input  wire                           obi0_req_i,     // Port 0 request
    input  wire wb_obi_pkg::obi_req_t     obi0_data_i,    // Port 0 payload
    output logic                          obi0_gnt_o,     // Port 0 grant
    output logic                          obi0_rvalid_o,  // Port 0 response valid
    output logic [wb_obi_pkg::DATA_W-1:0] obi0_rdata_o,   // Port 0 read data
    input  wire                           obi1_req_i,     // Port 1 request
    input  wire wb_obi_pkg::obi_req_t     obi1_data_i,    // Port 1 payload
    output logic                          obi1_gnt_o,     // Port 1 grant
    output logic                          obi1_rvalid_o,  // Port 1 response valid
    output logic [wb_obi_pkg::DATA_W-1:0] obi1_rdata_o    // Port 1 read data
);

    wb_obi_pkg::wb_req_t br0_req;  // Bridge 0 toward the arbiter
    wb_obi_pkg::wb_rsp_t br0_rsp;
    wb_obi_pkg::wb_req_t br1_req;  // Bridge 1 toward the arbiter
    wb_obi_pkg::wb_rsp_t br1_rsp;
    wb_obi_pkg::wb_req_t mem_req;  // Shared bus into the SRAM
    wb_obi_pkg::wb_rsp_t mem_rsp;

    obi_wb_bridge #(.MEM_AW(MEM_AW)) bridge_0_i (
        .wb_clk_i, .soc_rst_ni,
        .obi_req_i(obi0_req_i), .obi_req_data_i(obi0_data_i), .obi_gnt_o(obi0_gnt_o),
        .obi_rvalid_o(obi0_rvalid_o), .obi_rdata_o(obi0_rdata_o),
        .wb_req_o(br0_req), .wb_rsp_i(br0_rsp)
    );

    obi_wb_bridge #(.MEM_AW(MEM_AW)) bridge_1_i (
        .wb_clk_i, .soc_rst_ni,
        .obi_req_i(obi1_req_i), .obi_req_data_i(obi1_data_i), .obi_gnt_o(obi1_gnt_o),
        .obi_rvalid_o(obi1_rvalid_o), .obi_rdata_o(obi1_rdata_o),
        .wb_req_o(br1_req), .wb_rsp_i(br1_rsp)
    );

    wb_rr_arbiter arb_i (
        .wb_clk_i, .soc_rst_ni,
        .m0_req_i(br0_req), .m1_req_i(br1_req), .m0_rsp_o(br0_rsp), .m1_rsp_o(br1_rsp),
        .s_req_o(mem_req), .s_rsp_i(mem_rsp)
    );

    wb_sram #(.MEM_AW(MEM_AW)) sram_i (
        .wb_clk_i, .soc_rst_ni, .wb_req_i(mem_req), .wb_rsp_o(mem_rsp)
    );

endmodule

`default_nettype wire

/* obi_wb_subsys_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module obi_wb_subsys_tb;

    localparam int MEM_AW     = 10;  // Memory window used by the DUT
    localparam int RST_CYCLES = 10;  // Reset held low for this many clocks
    localparam int LINE_LIMIT = 40;  // Cycle budget granted to each case line

    // One port's share of a case line
    typedef struct packed {
        logic        en;     // Port takes part in this line
        logic        we;     // Write when high
        logic [31:0] addr;   // Byte address as issued by the master
        logic [3:0]  be;     // Byte enables
        logic [31:0] wdata;  // Write data
        logic [31:0] exp;    // Expected read data, ignored on writes
    } port_op_t;

    logic                 wb_clk_i;    // Bus clock
    logic                 soc_rst_ni;  // Active low reset
    logic [1:0]           req;         // OBI req, one bit per port
    wb_obi_pkg::obi_req_t data [2];    // OBI payload per port
    wire  [1:0]           gnt;         // OBI gnt per port
    wire  [1:0]           rvalid;      // OBI rvalid per port
    wire  [1:0][31:0]     rdata;       // OBI rdata per port

    logic [127:0] names [$];  // Test names in file order
    port_op_t     ops0 [$];   // Port 0 operations
    port_op_t     ops1 [$];   // Port 1 operations
    int           cycle_cnt   = 0;  // Clocks seen since time zero
    int           cycle_limit = 0;  // Set once the case file is loaded

    obi_wb_subsys #(.MEM_AW(MEM_AW)) dut_i (
        .wb_clk_i, .soc_rst_ni,
        .obi0_req_i(req[0]), .obi0_data_i(data[0]), .obi0_gnt_o(gnt[0]),
        .obi0_rvalid_o(rvalid[0]), .obi0_rdata_o(rdata[0]),
        .obi1_req_i(req[1]), .obi1_data_i(data[1]), .obi1_gnt_o(gnt[1]),
        .obi1_rvalid_o(rvalid[1]), .obi1_rdata_o(rdata[1])
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #10 wb_clk_i = ~wb_clk_i;  // 20 ns period
    end

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [127:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %0s expected %08h actual %08h", name, expected, actual);
            stop_run();
        end
    endtask

    // Watchdog that ends a stuck run once the budget for all lines is used up
    always @(posedge wb_clk_i) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, a port never saw gnt or rvalid", cycle_cnt);
            stop_run();
        end
    end

    task automatic load_cases();
        int          fd;
        int          cnt;
        string       line;
        logic [127:0] name;
        int          en0, we0, en1, we1;
        logic [31:0] a0, d0, x0, a1, d1, x1;
        logic [3:0]  b0, b1;
        fd = $fopen("obi_wb_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file obi_wb_cases.txt");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin  // Skip blank and comment lines
                cnt = $sscanf(line, "%s %d %d %h %h %h %h %d %d %h %h %h %h", name,
                              en0, we0, a0, b0, d0, x0, en1, we1, a1, b1, d1, x1);
                if (cnt != 13) begin
                    $display("Case line has %0d fields instead of 13: %s", cnt, line);
                    stop_run();
                end
                names.push_back(name);
                ops0.push_back('{en0[0], we0[0], a0, b0, d0, x0});
                ops1.push_back('{en1[0], we1[0], a1, b1, d1, x1});
            end
        end
        $fclose(fd);
        cycle_limit = LINE_LIMIT * names.size() + RST_CYCLES;  // Budget scales with the file
    endtask

    // Runs one OBI transfer on port p and checks its single rvalid pulse
    task automatic run_port(input int p, input port_op_t op, input logic [127:0] name);
        if (op.en) begin
            @(posedge wb_clk_i);
            #2;
            req[p]        = 1'b1;  // Request and payload change just after the edge
            data[p].addr  = op.addr;
            data[p].we    = op.we;
            data[p].be    = op.be;
            data[p].wdata = op.wdata;
            @(negedge wb_clk_i);
            while (!gnt[p]) begin
                @(negedge wb_clk_i);  // Busy bridge holds gnt low, keep req up
            end
            @(posedge wb_clk_i);  // Grant edge, payload captured here
            #2;
            req[p] = 1'b0;
            @(negedge wb_clk_i);
            while (!rvalid[p]) begin
                @(negedge wb_clk_i);
            end
            if (!op.we) begin
                check_value(name, op.exp, rdata[p]);  // Read data valid with rvalid
            end
            @(negedge wb_clk_i);
            if (rvalid[p]) begin
                $display("Port %0d in %0s held rvalid for more than one cycle", p, name);
                stop_run();
            end
        end
    endtask

    initial begin
        soc_rst_ni = 1'b0;
        req        = '0;
        data[0]    = '0;
        data[1]    = '0;
        load_cases();
        repeat (RST_CYCLES) begin
            @(negedge wb_clk_i);
            check_value("reset_gnt", 32'(2'b00), 32'(gnt));     // No request, so no grant
            check_value("reset_rvalid", 32'(2'b00), 32'(rvalid));
        end
        @(posedge wb_clk_i);
        #2;
        soc_rst_ni = 1'b1;
        @(negedge wb_clk_i);
        check_value("post_reset_gnt", 32'(2'b00), 32'(gnt));
        check_value("post_reset_rvalid", 32'(2'b00), 32'(rvalid));
        for (int i = 0; i < names.size(); i++) begin
            fork  // Both ports start in the same cycle
                run_port(0, ops0[i], names[i]);
                run_port(1, ops1[i], names[i]);
            join
        end
        $display("%0d case lines done in %0d cycles", names.size(), cycle_cnt);
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* obi_wb_cases.txt */
# name  port0: en we addr be wdata exp  port1: en we addr be wdata exp
# en and we are decimal, the other fields hex, exp is checked on reads only
wr_full    1 1 00000010 f deadbeef 00000000  0 0 00000000 0 00000000 00000000
rd_full    1 0 00000010 f 00000000 deadbeef  0 0 00000000 0 00000000 00000000
be_base    0 0 00000000 0 00000000 00000000  1 1 00000020 f 11223344 00000000
be_part    0 0 00000000 0 00000000 00000000  1 1 00000020 5 aabbccdd 00000000
be_read    0 0 00000000 0 00000000 00000000  1 0 00000020 f 00000000 11bb33dd
be_part2   0 0 00000000 0 00000000 00000000  1 1 00000020 a 99887766 00000000
be_read2   0 0 00000000 0 00000000 00000000  1 0 00000020 f 00000000 99bb77dd
share_wr   1 1 00000040 f cafef00d 00000000  0 0 00000000 0 00000000 00000000
share_rd   0 0 00000000 0 00000000 00000000  1 0 00000040 f 00000000 cafef00d
both_wr    1 1 00000080 f 01020304 00000000  1 1 00000084 f 05060708 00000000
both_rd    1 0 00000084 f 00000000 05060708  1 0 00000080 f 00000000 01020304
pre_own0   1 1 00000100 f 55555555 00000000  0 0 00000000 0 00000000 00000000
same_addr  1 1 00000100 f 0badc0de 00000000  1 0 00000100 f 00000000 55555555
same_after 0 0 00000000 0 00000000 00000000  1 0 00000100 f 00000000 0badc0de
alias_wr   1 1 fffff0c0 f 600df00d 00000000  0 0 00000000 0 00000000 00000000
alias_rd   0 0 00000000 0 00000000 00000000  1 0 000000c0 f 00000000 600df00d
alias_rd2  1 0 123450c0 f 00000000 600df00d  1 1 000004c4 f 0f0f0f0f 00000000
alias_rd3  1 0 000000c4 f 00000000 0f0f0f0f  0 0 00000000 0 00000000 00000000

/* obi_wb_subsys.f */
wb_obi_pkg.sv
obi_wb_bridge.sv
wb_rr_arbiter.sv
wb_sram.sv
obi_wb_subsys.sv
obi_wb_subsys_tb.sv

/* Bender.yml */
package:
  name: obi_wb_subsys

sources:
  - wb_obi_pkg.sv
  - obi_wb_bridge.sv
  - wb_rr_arbiter.sv
  - wb_sram.sv
  - obi_wb_subsys.sv
  - target: test
    files:
      - obi_wb_subsys_tb.sv
